// File: Makefile
TOP := tb_serial_link_rx

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		-f sources.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

// File: beat_fifo.sv
/*
  Circular beat buffer. FIFO_DEPTH must be a power of two of 2 or more.
  Full plus a read in the same cycle still accepts a write.
*/
`default_nettype none

module beat_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Write side
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  serial_link_pkg::beat_t in_data_i,
  // Read side
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output serial_link_pkg::beat_t out_data_o
);
  import serial_link_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  beat_t             mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              full;
  logic              empty;
  logic              push;
  logic              pop;

  assign full  = (count_q == CNT_W'(FIFO_DEPTH));
  assign empty = (count_q == '0);

  // A pending read frees a slot in the same cycle
  assign in_ready_o  = ~full | out_ready_i;
  assign out_valid_o = ~empty;
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  // Pointers wrap on their own with a power of two depth
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // Write while full lands on the slot that is being read out
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (full && push) |-> (wr_ptr_q == rd_ptr_q));

  // A read needs a stored beat, pointers apart unless wrapped full
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop |-> ((rd_ptr_q != wr_ptr_q) || full));

endmodule

`default_nettype wire

// File: dequeue_shift_register.sv
/*
  Splits a beat into messages at its start bits, one block shift per enabled cycle.
  The block shifted in at the top is always empty, no refill from a later beat.
  Requires 1 <= HDR_BITS <= BLOCK_SIZE-2.
*/
`default_nettype none

module dequeue_shift_register (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   align_en_i,
  // Beat input
  input  logic                   beat_valid_i,
  output logic                   beat_ready_o,
  input  serial_link_pkg::beat_t beat_data_i,
  // Message output
  msg_if.src                     msg
);
  import serial_link_pkg::*;

  localparam int STRIP_W = BLOCK_SIZE - 1;
  localparam int MSG_W   = $bits(msg_data_t);

  beat_t                               blocks_q;
  beat_t                               blocks_d;
  block_idx_t                          idx_q;
  block_idx_t                          idx_d;
  header_t                             header_q;
  logic                                held_q;
  logic                                first_q;
  logic                                start_bit;
  logic                                load;
  logic                                shift;
  logic                                take;
  logic                                consumed;
  logic [NUM_BLOCKS-1:0][STRIP_W-1:0]  stripped;
  msg_data_t                           stripped_flat;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  // Start bit of the block at position 0
  assign start_bit = blocks_q[0][HDR_BITS];

  assign msg.valid = held_q & start_bit;
  assign msg.first = msg.valid & first_q;
  assign take      = msg.valid & msg.ready;

  // Last block reached and its message, if any, leaves now
  assign consumed = held_q & (idx_q == block_idx_t'(NUM_BLOCKS - 1))
                  & (~start_bit | msg.ready);

  assign beat_ready_o = consumed | ~held_q;
  assign load         = beat_valid_i & beat_ready_o;

  // Move on past an empty position or a message being taken
  assign shift = held_q & ~load & align_en_i & (~start_bit | msg.ready);

  ////////////////////////////////////////
  // Block register next state
  ////////////////////////////////////////

  always_comb begin
    blocks_d = blocks_q;
    idx_d    = idx_q;
    if (load) begin
      blocks_d = beat_data_i;
      idx_d    = '0;
    end else if (shift) begin
      for (int i = 0; i < NUM_BLOCKS - 1; i++) begin
        blocks_d[i] = blocks_q[i+1];
      end
      // Empty block enters at the top
      blocks_d[NUM_BLOCKS-1] = '0;
      idx_d                  = idx_q + 1'b1;
    end else if (take) begin
      // Taken without a shift, drop the start bit so it is not sent twice
      blocks_d[0][HDR_BITS] = 1'b0;
    end
  end

  // Payload, no reset
  always_ff @(posedge clk_i) begin
    blocks_q <= blocks_d;
    if (load) begin
      header_q <= beat_data_i[0][HDR_BITS-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      held_q  <= 1'b0;
      first_q <= 1'b0;
      idx_q   <= '0;
    end else begin
      // Beat held until consumed, or replaced in the same cycle
      if (beat_ready_o) begin
        held_q <= beat_valid_i;
      end
      if (load) begin
        first_q <= 1'b1;
      end else if (take) begin
        first_q <= 1'b0;
      end
      idx_q <= idx_d;
    end
  end

  ////////////////////////////////////////
  // Output assembly
  ////////////////////////////////////////

  // Remove the start bit of each block
  for (genvar i = 0; i < NUM_BLOCKS; i++) begin : g_strip
    assign stripped[i] = {blocks_q[i][BLOCK_SIZE-1:HDR_BITS+1], blocks_q[i][HDR_BITS-1:0]};
  end

  assign stripped_flat = stripped;

  // Low bits carry the captured header
  assign msg.data = {stripped_flat[MSG_W-1:HDR_BITS], header_q};

  // Start bit index must fall inside a block
  a_hdr_fits: assert property (@(posedge clk_i) HDR_BITS < BLOCK_SIZE);

  // Pending message holds until taken
  a_msg_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (msg.valid && !msg.ready) |=> (msg.valid && $stable(msg.data) && $stable(msg.first)));

endmodule

`default_nettype wire

// File: msg_if.sv
/*
  One dequeued message with its valid/ready handshake and first-of-beat flag.
  data and first hold still while valid is high and ready is low.
*/
`default_nettype none

interface msg_if;
  import serial_link_pkg::*;

  // Handshake
  logic      valid;
  logic      ready;
  // Payload, start bits already removed
  msg_data_t data;
  // Set on the first message of a loaded beat
  logic      first;

  // Producer side
  modport src (output valid, output data, output first, input ready);

  // Consumer side
  modport dst (input valid, input data, input first, output ready);

  // Passive observer
  modport mon (input valid, input ready, input data, input first);

endinterface

`default_nettype wire

// File: rx_stats.sv
/*
  Message and beat counters, 16 bits each, wrapping.
  A beat is counted once, on its first message, so beats without start bits are not seen.
*/
`default_nettype none

module rx_stats (
  input  logic        clk_i,
  input  logic        rst_n_i,
  // Observed message stream
  msg_if.mon          msg,
  output logic [15:0] msg_count_o,
  output logic [15:0] beat_count_o
);

  logic xfer;

  // Message transfer this cycle
  assign xfer = msg.valid & msg.ready;

  ////////////////////////////////////////
  // Counters
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      msg_count_o  <= '0;
      beat_count_o <= '0;
    end else begin
      if (xfer) begin
        msg_count_o <= msg_count_o + 16'd1;
      end
      // First message stands for its whole beat
      if (xfer && msg.first) begin
        beat_count_o <= beat_count_o + 16'd1;
      end
    end
  end

  // first only rides on a valid message
  a_first_with_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    msg.first |-> msg.valid);

endmodule

`default_nettype wire

// File: serial_link_pkg.sv
/*
  Block geometry and shared types of the receive path.
  HDR_BITS must lie between 1 and BLOCK_SIZE-2, and NUM_BLOCKS must be 2 or more.
*/
`default_nettype none

package serial_link_pkg;

  ////////////////////////////////////////
  // Block geometry
  ////////////////////////////////////////

  // Bits per block, start bit included
  localparam int BLOCK_SIZE = 8;
  // Blocks per received beat
  localparam int NUM_BLOCKS = 4;
  // Header width, also the start bit position inside a block
  localparam int HDR_BITS   = 2;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [BLOCK_SIZE-1:0] block_t;

  // Block 0 sits in the least significant position
  typedef block_t [NUM_BLOCKS-1:0] beat_t;

  typedef logic [HDR_BITS-1:0] header_t;

  // One start bit less per block
  typedef logic [NUM_BLOCKS*(BLOCK_SIZE-1)-1:0] msg_data_t;

  typedef logic [$clog2(NUM_BLOCKS)-1:0] block_idx_t;

endpackage

`default_nettype wire

// File: serial_link_rx.sv
/*
  Receive-side block dequeue. Beats pass a FIFO, then the shift register splits them
  into messages. Beat-to-message latency varies, msg_valid_o marks each message.
*/
`default_nettype none

module serial_link_rx #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       align_en_i,
  // Beats from the physical layer
  input  logic                       beat_valid_i,
  output logic                       beat_ready_o,
  input  serial_link_pkg::beat_t     beat_data_i,
  // Dequeued messages
  output logic                       msg_valid_o,
  input  logic                       msg_ready_i,
  output serial_link_pkg::msg_data_t msg_data_o,
  output logic                       msg_first_o,
  // Statistics
  output logic [15:0]                msg_count_o,
  output logic [15:0]                beat_count_o
);
  import serial_link_pkg::*;

  // FIFO to shift register
  logic  fifo_valid;
  logic  fifo_ready;
  beat_t fifo_data;

  msg_if u_msg ();

  // Consumer side of the message bus
  assign u_msg.ready = msg_ready_i;
  assign msg_valid_o = u_msg.valid;
  assign msg_data_o  = u_msg.data;
  assign msg_first_o = u_msg.first;

  beat_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (beat_valid_i),
    .in_ready_o  (beat_ready_o),
    .in_data_i   (beat_data_i),
    .out_valid_o (fifo_valid),
    .out_ready_i (fifo_ready),
    .out_data_o  (fifo_data)
  );

  dequeue_shift_register u_dsr (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .align_en_i   (align_en_i),
    .beat_valid_i (fifo_valid),
    .beat_ready_o (fifo_ready),
    .beat_data_i  (fifo_data),
    .msg          (u_msg.src)
  );

  rx_stats u_stats (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .msg          (u_msg.mon),
    .msg_count_o  (msg_count_o),
    .beat_count_o (beat_count_o)
  );

endmodule

`default_nettype wire

// File: sources.f
serial_link_pkg.sv
msg_if.sv
beat_fifo.sv
dequeue_shift_register.sv
rx_stats.sv
serial_link_rx.sv
tb_clk_gen.sv
tb_serial_link_rx.sv

// File: tb_clk_gen.sv
/*
  Free-running testbench clock, 8 ns period, starts low.
*/
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_PERIOD_NS = 4
) (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Toggle forever, the run ends by $finish
  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// File: tb_serial_link_rx.sv
/*
  Random beats against a message model, then a back-pressure stall and a final drain.
  Inputs change on falling edges, outputs are sampled on rising edges.
*/
`default_nettype none

module tb_serial_link_rx;
  timeunit 1ns;
  timeprecision 100ps;
  import serial_link_pkg::*;

  localparam int FIFO_DEPTH   = 4;
  localparam int NUM_BEATS    = 300;
  localparam int TIMEOUT      = 2000;
  // Longest message-free stretch while FIFO and shift register flush
  localparam int QUIET_CYCLES = (FIFO_DEPTH + 1) * (NUM_BLOCKS + 1) + 2;

  logic clk, rst_n, align_en, beat_valid, beat_ready, msg_valid, msg_ready, msg_first;
  beat_t       beat_data;
  msg_data_t   msg_data;
  logic [15:0] msg_count, beat_count;

  // Model queues, one entry per expected message
  msg_data_t exp_data_q [$];
  logic      exp_first_q [$];
  int        exp_msg_count, exp_beat_count;
  int        err_msg, err_count, err_other, timeouts;
  logic      timed_out;
  // Pending message seen at the previous edge
  logic      hold;
  msg_data_t held_data;
  logic      held_first;

  tb_clk_gen u_clk (.clk_o(clk));

  serial_link_rx #(.FIFO_DEPTH(FIFO_DEPTH)) u_dut (
    .clk_i(clk), .rst_n_i(rst_n), .align_en_i(align_en),
    .beat_valid_i(beat_valid), .beat_ready_o(beat_ready), .beat_data_i(beat_data),
    .msg_valid_o(msg_valid), .msg_ready_i(msg_ready), .msg_data_o(msg_data),
    .msg_first_o(msg_first), .msg_count_o(msg_count), .beat_count_o(beat_count)
  );

  ////////////////////////////////////////
  // Reference model and compare tasks
  ////////////////////////////////////////

  // Blocks k and up, start bits dropped, empty blocks above, header in the low bits
  function automatic msg_data_t expected_msg(input beat_t b, input int k);
    msg_data_t m;
    int        out;
    m   = '0;
    out = 0;
    for (int pos = 0; pos < NUM_BLOCKS; pos++) begin
      for (int bi = 0; bi < BLOCK_SIZE; bi++) begin
        if (bi != HDR_BITS) begin
          if (k + pos < NUM_BLOCKS) m[out] = b[k+pos][bi];
          out++;
        end
      end
    end
    for (int bi = 0; bi < HDR_BITS; bi++) m[bi] = b[0][bi];
    return m;
  endfunction

  // One expected message per set start bit, in block order
  task automatic queue_beat(input beat_t b);
    logic seen;
    seen = 1'b0;
    for (int k = 0; k < NUM_BLOCKS; k++) begin
      if (b[k][HDR_BITS]) begin
        exp_data_q.push_back(expected_msg(b, k));
        exp_first_q.push_back(!seen);
        exp_msg_count++;
        seen = 1'b1;
      end
    end
    if (seen) exp_beat_count++;
  endtask

  task automatic check_msg(input string what, input msg_data_t exp_data, input logic exp_first,
                           input msg_data_t got_data, input logic got_first);
    if (got_data !== exp_data || got_first !== exp_first) begin
      err_msg++;
      $display("error %s: msg_data_o %h expected %h, msg_first_o %h expected %h",
               what, got_data, exp_data, got_first, exp_first);
    end
  endtask

  task automatic check_count(input string name, input logic [15:0] exp, input logic [15:0] got);
    if (got !== exp) begin
      err_count++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      err_other++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  // Message monitor, runs before any NBA update of the edge
  always @(posedge clk) begin
    if (!rst_n) begin
      hold = 1'b0;
    end else begin
      if (hold) begin
        if (!msg_valid) begin
          err_other++;
          $display("pending message withdrawn before it was taken");
        end else begin
          check_msg("held message", held_data, held_first, msg_data, msg_first);
        end
      end
      if (msg_valid && msg_ready) begin
        if (exp_data_q.size() == 0) begin
          err_other++;
          $display("message delivered with none expected, data %h", msg_data);
        end else begin
          check_msg("message", exp_data_q.pop_front(), exp_first_q.pop_front(),
                    msg_data, msg_first);
        end
      end
      // Accepted beats cannot yield a message in the same cycle
      if (beat_valid && beat_ready) queue_beat(beat_data);
      hold       = msg_valid && !msg_ready;
      held_data  = msg_data;
      held_first = msg_first;
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic report_timeout(input string what);
    timeouts++;
    timed_out = 1'b1;
    $display("timeout: %s within %0d cycles", what, TIMEOUT);
  endtask

  // Sink mostly ready, shifting mostly enabled
  task automatic randomize_sink();
    msg_ready = ($urandom_range(0, 9) < 7);
    align_en  = ($urandom_range(0, 9) < 9);
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    beat_valid = 1'b0;
    randomize_sink();
    @(posedge clk);
  endtask

  // Present one beat and hold it until the FIFO takes it
  task automatic send_beat(input beat_t b);
    int cycles;
    cycles = 0;
    @(negedge clk);
    beat_valid = 1'b1;
    beat_data  = b;
    randomize_sink();
    @(posedge clk);
    while (!beat_ready && !timed_out) begin
      cycles++;
      if (cycles >= TIMEOUT) begin
        report_timeout("beat not accepted");
      end else begin
        @(negedge clk);
        randomize_sink();
        @(posedge clk);
      end
    end
  endtask

  // Sink ready until no message has shown up for a whole flush of FIFO and shift register
  task automatic drain();
    int cycles;
    int quiet;
    cycles = 0;
    quiet  = 0;
    @(negedge clk);
    beat_valid = 1'b0;
    msg_ready  = 1'b1;
    align_en   = 1'b1;
    while (!timed_out && quiet < QUIET_CYCLES) begin
      @(negedge clk);
      if (msg_valid) begin
        quiet = 0;
      end else begin
        quiet++;
      end
      cycles++;
      if (cycles >= TIMEOUT) report_timeout("messages still pending");
    end
  endtask

  // Sink held off, beats with a start bit in block 0 pile up until input ready falls
  task automatic stall_inputs();
    int    cycles;
    int    accepted;
    logic  stalled;
    beat_t b;
    cycles   = 0;
    accepted = 0;
    stalled  = 1'b0;
    b        = $urandom;
    b[0][HDR_BITS] = 1'b1;
    @(negedge clk);
    msg_ready  = 1'b0;
    align_en   = 1'b1;
    beat_valid = 1'b1;
    beat_data  = b;
    while (!stalled && !timed_out) begin
      @(posedge clk);
      if (beat_ready) begin
        accepted++;
        b = $urandom;
        b[0][HDR_BITS] = 1'b1;
      end else if (msg_valid) begin
        stalled = 1'b1;
      end
      if (!stalled) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
          report_timeout("beat_ready_o did not fall under back-pressure");
        end else begin
          @(negedge clk);
          beat_data = b;
        end
      end
    end
    // FIFO full plus the beat held in the shift register
    if (!timed_out) check_count("beats accepted before stall", 16'(FIFO_DEPTH + 1), 16'(accepted));
    @(negedge clk);
    beat_valid = 1'b0;
  endtask

  task automatic finish_run();
    $display("errors: message %0d, count %0d, other %0d, timeout %0d",
             err_msg, err_count, err_other, timeouts);
    if (err_msg + err_count + err_other + timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  initial begin
    rst_n      = 1'b0;
    align_en   = 1'b0;
    beat_valid = 1'b0;
    beat_data  = '0;
    msg_ready  = 1'b0;
    hold       = 1'b0;
    timed_out  = 1'b0;
    {err_msg, err_count, err_other, timeouts} = '0;
    {exp_msg_count, exp_beat_count}           = '0;
    void'($urandom(32'h4eaa_716b));
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Idle state straight out of reset
    @(negedge clk);
    check_flag("msg_valid_o after reset", 1'b0, msg_valid);
    check_flag("beat_ready_o after reset", 1'b1, beat_ready);
    check_count("msg_count_o after reset", 16'h0, msg_count);
    check_count("beat_count_o after reset", 16'h0, beat_count);
    for (int n = 0; n < NUM_BEATS && !timed_out; n++) begin
      repeat ($urandom_range(0, 3)) idle_cycle();
      send_beat($urandom);
    end
    if (!timed_out) drain();
    if (!timed_out) stall_inputs();
    if (!timed_out) drain();
    if (!timed_out) begin
      check_count("msg_count_o", 16'(exp_msg_count), msg_count);
      check_count("beat_count_o", 16'(exp_beat_count), beat_count);
      if (exp_data_q.size() != 0) begin
        err_other++;
        $display("expected messages left over after the drain");
      end
    end
    finish_run();
  end

endmodule

`default_nettype wire
